// File: flist.f
dibit_link_pkg.sv
stream_pack.sv
stream_unpack.sv
frame_writer.sv
packet_ram.sv
frame_reader.sv
dibit_loopback_top.sv
tb_dibit_loopback.sv

// File: Bender.yml
package:
  name: dibit_loopback

sources:
  - dibit_link_pkg.sv
  - stream_pack.sv
  - stream_unpack.sv
  - frame_writer.sv
  - packet_ram.sv
  - frame_reader.sv
  - dibit_loopback_top.sv
  - target: test
    files:
      - tb_dibit_loopback.sv

// File: tb_dibit_loopback.sv
/*
 * testbench for the dibit loopback buffer with a frame table,
 * dibit and done checks, and a watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dibit_loopback;

	import dibit_link_pkg::*;

	localparam int RAM_LAT = 2;
	localparam int NUM_ROWS = 4;
	localparam int DIBITS_PER_BYTE = BYTE_LEN / DIBIT_LEN;
	localparam int MARGIN = 500;

	// one row per frame with its name, write offset, byte count, fill seed and wrap flag
	string row_name [NUM_ROWS] = '{"aligned", "offset_mid", "wrap_top", "single"};
	addr_t row_offset [NUM_ROWS] = '{8'h10, 8'h80, 8'hf4, 8'h30};
	int row_count [NUM_ROWS] = '{16, 20, 24, 1};
	byte_t row_fill [NUM_ROWS] = '{8'h00, 8'h5a, 8'hc3, 8'h81};
	bit row_wrap [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0};

	logic clk = 1'b0;
	logic rst;
	logic rx_valid;
	dibit_t rx_dibit;
	logic rx_last;
	logic wr_offset_load;
	addr_t wr_offset;
	logic tx_start;
	addr_t tx_read_start;
	addr_t tx_read_end;
	logic tx_valid;
	dibit_t tx_dibit;
	logic tx_done;

	byte_t model [PACKET_BUFFER_SIZE];
	dibit_t got_q [$];
	integer seed = 32'h3565a070;
	int errors = 0;
	int tests = 0;
	int failed = 0;
	int done_seen = 0;
	int done_pos = -1;
	bit rd_armed = 1'b0;

	dibit_loopback_top #(
		.RAM_READ_LATENCY(RAM_LAT)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.rx_valid(rx_valid),
		.rx_dibit(rx_dibit),
		.rx_last(rx_last),
		.wr_offset_load(wr_offset_load),
		.wr_offset(wr_offset),
		.tx_start(tx_start),
		.tx_read_start(tx_read_start),
		.tx_read_end(tx_read_end),
		.tx_valid(tx_valid),
		.tx_dibit(tx_dibit),
		.tx_done(tx_done)
	);

	always #10 clk = ~clk;

	// the transmit monitor samples on the rising edge while inputs move on the falling one
	always @(posedge clk) begin
		if (!rst) begin
			if (tx_valid !== 1'b0) begin
				if (rd_armed) begin
					got_q.push_back(tx_dibit);
				end else begin
					errors++;
					$display("Error: tx_valid high with no read in progress at %0t", $time);
				end
			end
			if (tx_done !== 1'b0) begin
				if (!rd_armed) begin
					errors++;
					$display("Error: tx_done pulse with no read in progress at %0t", $time);
				end
				if (tx_valid !== 1'b1) begin
					errors++;
					$display("Error: tx_done pulse without a dibit at %0t", $time);
				end
				done_seen++;
				done_pos = got_q.size();
				rd_armed = 1'b0;
			end
		end
	end

	task automatic check_dibit(input string name, input int idx, input dibit_t exp,
			input dibit_t act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s dibit %0d: expected %0d actual %0d", name, idx, exp, act);
		end
	endtask

	task automatic check_done_count(input string name, input int exp, input int act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic write_frame(input int row);
		addr_t addr;
		byte_t data;
		int gap;
		wr_offset_load = 1'b1;
		wr_offset = row_offset[row];
		@(negedge clk);
		wr_offset_load = 1'b0;
		for (int i = 0; i < row_count[row]; i++) begin
			addr = addr_t'(row_offset[row] + i);
			data = byte_t'($random(seed)) ^ row_fill[row];
			model[addr] = data;
			// dibits go out low pair first with idle cycles of random length in between
			for (int k = 0; k < DIBITS_PER_BYTE; k++) begin
				gap = $random(seed) & 1;
				repeat (gap) @(negedge clk);
				rx_valid = 1'b1;
				rx_dibit = data[DIBIT_LEN*k +: DIBIT_LEN];
				rx_last = (i == row_count[row] - 1) && (k == DIBITS_PER_BYTE - 1);
				@(negedge clk);
				rx_valid = 1'b0;
				rx_last = 1'b0;
			end
		end
	endtask

	task automatic read_frame(input string name, input int row);
		addr_t first;
		int span;
		int n_dibits;
		int limit;
		int cycles;
		int err_before;
		byte_t data;
		err_before = errors;
		first = row_offset[row];
		span = row_offset[row] + row_count[row];
		n_dibits = row_count[row] * DIBITS_PER_BYTE;
		limit = row_count[row] * (DIBITS_PER_BYTE + RAM_LAT + 2) + 20;
		got_q.delete();
		done_seen = 0;
		done_pos = -1;
		tx_start = 1'b1;
		tx_read_start = first;
		// end address is exclusive and drops below the start on a wrapping frame
		tx_read_end = addr_t'(row_wrap[row] ? span - PACKET_BUFFER_SIZE : span);
		rd_armed = 1'b1;
		@(negedge clk);
		tx_start = 1'b0;
		cycles = 0;
		while (done_seen == 0 && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		// stray dibits after the done pulse get time to show up here
		repeat (RAM_LAT + 8) @(negedge clk);
		if (done_seen == 0) begin
			errors++;
			rd_armed = 1'b0;
			$display("Error: %s saw no tx_done within %0d cycles", name, limit);
		end else begin
			check_done_count({name, " done pulses"}, 1, done_seen);
			check_done_count({name, " done position"}, n_dibits, done_pos);
		end
		if (got_q.size() > n_dibits) begin
			errors++;
			$display("Error: %s received %0d dibits, more than the %0d sent", name,
				got_q.size(), n_dibits);
		end else if (got_q.size() < n_dibits) begin
			errors++;
			$display("Error: %s received only %0d of %0d dibits", name, got_q.size(), n_dibits);
		end
		for (int i = 0; i < got_q.size() && i < n_dibits; i++) begin
			data = model[addr_t'(first + i / DIBITS_PER_BYTE)];
			check_dibit(name, i, data[DIBIT_LEN*(i%DIBITS_PER_BYTE) +: DIBIT_LEN], got_q[i]);
		end
		tests++;
		if (errors == err_before) begin
			$display("Pass %s: %0d bytes from %02h to %02h", name, row_count[row], first,
				tx_read_end);
		end else begin
			failed++;
			$display("Done %s with %0d errors", name, errors - err_before);
		end
	endtask

	initial begin
		rst = 1'b1;
		rx_valid = 1'b0;
		rx_dibit = '0;
		rx_last = 1'b0;
		wr_offset_load = 1'b0;
		wr_offset = '0;
		tx_start = 1'b0;
		tx_read_start = '0;
		tx_read_end = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			write_frame(r);
			repeat (4) @(negedge clk);
			read_frame(row_name[r], r);
		end
		// every frame must still be intact after the writes that followed it
		for (int r = 0; r < NUM_ROWS; r++)
			read_frame({row_name[r], "_reread"}, r);
		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// each table frame is written once and read twice
	initial begin
		int total_bytes;
		int limit;
		total_bytes = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			total_bytes += 2 * row_count[r];
		limit = (total_bytes * DIBITS_PER_BYTE + RAM_LAT) * 4 + MARGIN;
		#(limit * 20);
		$display("Error: watchdog expired after %0d cycles", limit);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: dibit_loopback_top.sv
/*
 * dibit loopback frame buffer, receive packer and writer, packet RAM,
 * reader and transmit unpacker
 */
`timescale 1ns/1ps
`default_nettype none

module dibit_loopback_top #(
	parameter int RAM_READ_LATENCY = dibit_link_pkg::DEFAULT_READ_LATENCY
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rx_valid,
	input  dibit_link_pkg::dibit_t rx_dibit,
	input  logic                   rx_last,
	input  logic                   wr_offset_load,
	input  dibit_link_pkg::addr_t  wr_offset,
	input  logic                   tx_start,
	input  dibit_link_pkg::addr_t  tx_read_start,
	input  dibit_link_pkg::addr_t  tx_read_end,
	output logic                   tx_valid,
	output dibit_link_pkg::dibit_t tx_dibit,
	output logic                   tx_done
);

	import dibit_link_pkg::*;

	logic  rx_byte_valid;
	byte_t rx_byte;
	logic  ram_we;
	addr_t ram_waddr;
	byte_t ram_wdata;
	logic  ram_re;
	addr_t ram_raddr;
	logic  ram_rvalid;
	byte_t ram_rdata;
	logic  rd_done;
	logic  unpack_rdy;

	// frame boundaries on the receive side come from the write offset,
	// so the packer's done output stays open
	stream_pack #(
		.S_LEN(DIBIT_LEN),
		.L_LEN(BYTE_LEN)
	) i_pack (
		.clk(clk),
		.rst(rst),
		.inclk(rx_valid),
		.in(rx_dibit),
		.in_done(rx_last),
		.outclk(rx_byte_valid),
		.out(rx_byte),
		.done()
	);

	frame_writer i_writer (
		.clk(clk),
		.rst(rst),
		.offset_load(wr_offset_load),
		.offset(wr_offset),
		.inclk(rx_byte_valid),
		.in(rx_byte),
		.we(ram_we),
		.waddr(ram_waddr),
		.wdata(ram_wdata)
	);

	packet_ram #(
		.RAM_READ_LATENCY(RAM_READ_LATENCY)
	) i_ram (
		.clk(clk),
		.rst(rst),
		.we(ram_we),
		.waddr(ram_waddr),
		.wdata(ram_wdata),
		.re(ram_re),
		.raddr(ram_raddr),
		.rvalid(ram_rvalid),
		.rdata(ram_rdata)
	);

	frame_reader #(
		.RAM_READ_LATENCY(RAM_READ_LATENCY)
	) i_reader (
		.clk(clk),
		.rst(rst),
		.start(tx_start),
		.read_start(tx_read_start),
		.read_end(tx_read_end),
		.down_rdy(unpack_rdy),
		.ram_rvalid(ram_rvalid),
		.re(ram_re),
		.raddr(ram_raddr),
		.done(rd_done)
	);

	stream_unpack #(
		.S_LEN(DIBIT_LEN),
		.L_LEN(BYTE_LEN)
	) i_unpack (
		.clk(clk),
		.rst(rst),
		.inclk(ram_rvalid),
		.in(ram_rdata),
		.in_done(rd_done),
		.outclk(tx_valid),
		.out(tx_dibit),
		.rdy(unpack_rdy),
		.done(tx_done)
	);

endmodule

`default_nettype wire

// File: frame_reader.sv
/*
 * packet buffer read sequencer, one outstanding read at a time,
 * with a done flag aligned to the returning data
 */
`timescale 1ns/1ps
`default_nettype none

module frame_reader #(
	parameter int RAM_READ_LATENCY = dibit_link_pkg::DEFAULT_READ_LATENCY
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  dibit_link_pkg::addr_t read_start,
	input  dibit_link_pkg::addr_t read_end,
	input  logic                  down_rdy,
	input  logic                  ram_rvalid,
	output logic                  re,
	output dibit_link_pkg::addr_t raddr,
	output logic                  done
);

	import dibit_link_pkg::*;

	addr_t curr_addr;
	addr_t end_addr;
	addr_t next_addr;
	logic first_word;
	logic waiting;
	logic idle;
	logic last_issue;
	logic [RAM_READ_LATENCY-1:0] last_pipe;

	assign next_addr = (curr_addr == addr_t'(PACKET_BUFFER_SIZE - 1)) ?
		'0 : curr_addr + 1'b1;

	// with start equal to end, the first word flag keeps a full wrap from
	// looking like an empty range
	assign idle = !first_word && (curr_addr == end_addr);

	// the unpacker must have taken the previous byte before the next request
	assign re = down_rdy && !idle && !waiting && !start;
	assign raddr = curr_addr;

	// end address is exclusive, so the last read is the one just before it
	assign last_issue = re && (next_addr == end_addr);
	assign done = last_pipe[RAM_READ_LATENCY-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			curr_addr <= '0;
			end_addr <= '0;
			first_word <= 1'b0;
		end else if (start) begin
			curr_addr <= read_start;
			end_addr <= read_end;
			first_word <= 1'b1;
		end else if (re) begin
			curr_addr <= next_addr;
			first_word <= 1'b0;
		end
	end

	// a read stays outstanding until its data comes back
	always_ff @(posedge clk) begin
		if (rst)
			waiting <= 1'b0;
		else if (ram_rvalid)
			waiting <= 1'b0;
		else if (re)
			waiting <= 1'b1;
	end

	// same depth as the RAM read pipeline
	always_ff @(posedge clk) begin
		if (rst)
			last_pipe <= '0;
		else begin
			last_pipe[0] <= last_issue;
			for (int i = 1; i < RAM_READ_LATENCY; i++)
				last_pipe[i] <= last_pipe[i-1];
		end
	end

endmodule

`default_nettype wire

// File: packet_ram.sv
/*
 * simple dual-port packet buffer with a configurable read pipeline
 */
`timescale 1ns/1ps
`default_nettype none

module packet_ram #(
	parameter int RAM_READ_LATENCY = dibit_link_pkg::DEFAULT_READ_LATENCY
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  we,
	input  dibit_link_pkg::addr_t waddr,
	input  dibit_link_pkg::byte_t wdata,
	input  logic                  re,
	input  dibit_link_pkg::addr_t raddr,
	output logic                  rvalid,
	output dibit_link_pkg::byte_t rdata
);

	import dibit_link_pkg::*;

	byte_t mem [PACKET_BUFFER_SIZE];
	byte_t data_pipe [RAM_READ_LATENCY];
	logic [RAM_READ_LATENCY-1:0] valid_pipe;

	assign rdata = data_pipe[RAM_READ_LATENCY-1];
	assign rvalid = valid_pipe[RAM_READ_LATENCY-1];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// the first stage is the array read itself
	always_ff @(posedge clk) begin
		if (re)
			data_pipe[0] <= mem[raddr];
		for (int i = 1; i < RAM_READ_LATENCY; i++)
			data_pipe[i] <= data_pipe[i-1];
	end

	always_ff @(posedge clk) begin
		if (rst)
			valid_pipe <= '0;
		else begin
			valid_pipe[0] <= re;
			for (int i = 1; i < RAM_READ_LATENCY; i++)
				valid_pipe[i] <= valid_pipe[i-1];
		end
	end

endmodule

`default_nettype wire

// File: frame_writer.sv
/*
 * byte stream to RAM write cycles at an auto-incrementing address
 * with a loadable start offset
 */
`timescale 1ns/1ps
`default_nettype none

module frame_writer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  offset_load,
	input  dibit_link_pkg::addr_t offset,
	input  logic                  inclk,
	input  dibit_link_pkg::byte_t in,
	output logic                  we,
	output dibit_link_pkg::addr_t waddr,
	output dibit_link_pkg::byte_t wdata
);

	import dibit_link_pkg::*;

	addr_t curr_addr;
	addr_t next_addr;

	assign next_addr = (curr_addr == addr_t'(PACKET_BUFFER_SIZE - 1)) ?
		'0 : curr_addr + 1'b1;

	// a new frame may begin anywhere in the buffer
	always_ff @(posedge clk) begin
		if (rst) begin
			curr_addr <= '0;
			we <= 1'b0;
		end else begin
			if (offset_load)
				curr_addr <= offset;
			else if (inclk)
				curr_addr <= next_addr;
			we <= inclk;
		end
	end

	// address and data are captured together with the strobe
	always_ff @(posedge clk) begin
		if (inclk) begin
			waddr <= curr_addr;
			wdata <= in;
		end
	end

endmodule

`default_nettype wire

// File: stream_unpack.sv
/*
 * wide to narrow word unpacker with a ready level and a done pulse
 * on the final slice of a marked word
 */
`timescale 1ns/1ps
`default_nettype none

module stream_unpack #(
	parameter int S_LEN = 2,
	parameter int L_LEN = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             inclk,
	input  logic [L_LEN-1:0] in,
	input  logic             in_done,
	output logic             outclk,
	output logic [S_LEN-1:0] out,
	output logic             rdy,
	output logic             done
);

	localparam int PACK_RATIO = L_LEN / S_LEN;
	localparam int CNT_LEN = $clog2(PACK_RATIO);
	localparam logic [CNT_LEN-1:0] CNT_LAST = CNT_LEN'(PACK_RATIO - 1);

	logic [L_LEN-S_LEN-1:0] shifted;
	logic [CNT_LEN-1:0] cnt;
	logic idle;
	logic done_found;

	assign idle = (cnt == '0);
	assign rdy = idle;

	// the low slice of a new word bypasses the shift register
	assign outclk = inclk || !idle;
	assign out = inclk ? in[S_LEN-1:0] : shifted[S_LEN-1:0];

	// words only arrive while idle, so the flag belongs to the word in flight
	assign done = done_found && (cnt == CNT_LAST);

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			done_found <= 1'b0;
		end else begin
			if (outclk)
				cnt <= cnt + 1'b1;
			if (inclk)
				done_found <= in_done;
			else if (done)
				done_found <= 1'b0;
		end
	end

	// remaining slices drain low first, one per cycle
	always_ff @(posedge clk) begin
		if (inclk)
			shifted <= in[L_LEN-1:S_LEN];
		else if (outclk)
			shifted <= shifted >> S_LEN;
	end

endmodule

`default_nettype wire

// File: stream_pack.sv
/*
 * narrow to wide word packer, first narrow word lands in the low bits
 */
`timescale 1ns/1ps
`default_nettype none

module stream_pack #(
	parameter int S_LEN = 2,
	parameter int L_LEN = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             inclk,
	input  logic [S_LEN-1:0] in,
	input  logic             in_done,
	output logic             outclk,
	output logic [L_LEN-1:0] out,
	output logic             done
);

	localparam int PACK_RATIO = L_LEN / S_LEN;
	localparam int CNT_LEN = $clog2(PACK_RATIO);
	localparam logic [CNT_LEN-1:0] CNT_LAST = CNT_LEN'(PACK_RATIO - 1);

	// the last narrow word is never stored, it goes straight to the output
	logic [L_LEN-S_LEN-1:0] shifted;
	logic [L_LEN-1:0] joined;
	logic [CNT_LEN-1:0] cnt;

	assign joined = {in, shifted};
	assign out = joined;
	assign outclk = inclk && (cnt == CNT_LAST);
	assign done = in_done;

	// in_done closes a partial word so the next frame starts aligned
	always_ff @(posedge clk) begin
		if (rst)
			cnt <= '0;
		else if (in_done)
			cnt <= '0;
		else if (inclk)
			cnt <= cnt + 1'b1;
	end

	// older words move toward the low end as new ones arrive
	always_ff @(posedge clk) begin
		if (inclk)
			shifted <= joined[L_LEN-1:S_LEN];
	end

endmodule

`default_nettype wire

// File: dibit_link_pkg.sv
/*
 * shared widths, vector typedefs and packet buffer constants
 * for the dibit loopback buffer
 */
`default_nettype none

package dibit_link_pkg;

	// buffer side and line side word sizes
	localparam int BYTE_LEN = 8;
	localparam int DIBIT_LEN = 2;

	// packet buffer geometry
	localparam int ADDR_LEN = 8;
	localparam int PACKET_BUFFER_SIZE = 256;

	// read latency used when the top level does not override it
	localparam int DEFAULT_READ_LATENCY = 1;

	typedef logic [BYTE_LEN-1:0] byte_t;
	typedef logic [DIBIT_LEN-1:0] dibit_t;
	typedef logic [ADDR_LEN-1:0] addr_t;

endpackage

`default_nettype wire
